//--- ice_spi_params.svh
`ifndef ICE_SPI_PARAMS_SVH
`define ICE_SPI_PARAMS_SVH

// ==============================
// Command message
// ==============================
`define MSG_LEN             64
`define MSG_TYPE_LEN        8
`define MSG_ARG_LEN         56
`define MSG_TYPE_BITS       63:56
`define MSG_ARG_BITS        55:0

// Host sends one dummy byte ahead of every message
`define DUMMY_NIBBLES       2
`define MSG_NIBBLES         ((`MSG_LEN/4)+`DUMMY_NIBBLES)

// Type bit that asks for a response
`define MSG_TYPE_RESP_BIT   6

`define MSG_TYPE_NOP        8'h80
`define MSG_TYPE_LEDSET     8'h81
`define MSG_TYPE_SDINIT     8'h82
`define MSG_TYPE_ECHO       8'hC0

// ==============================
// Response
// ==============================
`define RESP_LEN            64
`define RESP_BYTES          8
`define RESP_ECHO_MSG_BITS  63:8
`define RESP_TAIL_BITS      7:0

`endif

//--- ice_msg_pkg.sv
`default_nettype none

`include "ice_spi_params.svh"

package ice_msg_pkg;

    // Message type after the top bit is forced high
    typedef logic [`MSG_TYPE_LEN-1:0] msg_type_t;

    // LEDSet argument
    typedef struct packed {
        logic [`MSG_ARG_LEN-5:0] pad;
        logic [3:0]              val;
    } led_set_arg_t;

    // SDInit argument, reset in the lowest bit
    typedef struct packed {
        logic [`MSG_ARG_LEN-9:0] pad;
        logic [3:0]              clk_delay;
        logic [1:0]              clk_speed;
        logic                    trigger;
        logic                    reset;
    } sd_init_arg_t;

    // ==============================
    // Argument field, one view per command
    // ==============================
    typedef union packed {
        logic [`MSG_ARG_LEN-1:0] echo_msg;
        led_set_arg_t            led_set;
        sd_init_arg_t            sd_init;
    } msg_arg_u;

endpackage

`default_nettype wire

//--- msg_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "ice_spi_params.svh"

// Quad-SPI command shift-in.
// One message per chip-select, dummy lead-in included in the count.
module msg_receiver (
    input  wire logic             ice_st_spi_clk,
    input  wire logic             spi_cs,
    input  wire logic [3:0]       d_nibble,
    output logic                  msg_valid,
    output logic [7:0]            msg_type_raw,
    output ice_msg_pkg::msg_arg_u msg_arg
);

    // Wide enough to hold the full nibble count
    localparam int unsigned CNT_W = $clog2(`MSG_NIBBLES + 1);

    logic [CNT_W-1:0]    nib_cnt;
    logic                done;
    logic [`MSG_LEN-1:0] shreg;

    // ==============================
    // Nibble counter and done flag
    // ==============================
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            nib_cnt   <= CNT_W'(`MSG_NIBBLES);
            done      <= 1'b0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (!done) begin
                nib_cnt <= nib_cnt - 1'b1;
                // Last nibble arriving on this edge
                if (nib_cnt == CNT_W'(1)) begin
                    done      <= 1'b1;
                    msg_valid <= 1'b1;
                end
            end
        end
    end

    // ==============================
    // Message shift register
    // ==============================
    // MSB nibble first. The dummy nibbles fall off the top
    // once all sixteen message nibbles are in.
    always_ff @(posedge ice_st_spi_clk) begin
        if (!done) begin
            shreg <= {shreg[`MSG_LEN-5:0], d_nibble};
        end
    end

    // Held stable once done until the next select
    assign msg_type_raw = shreg[`MSG_TYPE_BITS];
    assign msg_arg      = shreg[`MSG_ARG_BITS];

endmodule

`default_nettype wire

//--- msg_executor.sv
`timescale 1ns/1ps
`default_nettype none

`include "ice_spi_params.svh"

// Command decode and execution.
// LED and SD-init state live here and survive deselect.
module msg_executor (
    input  wire logic                  ice_st_spi_clk,
    input  wire logic                  spi_cs,
    input  wire logic                  msg_valid,
    input  wire logic [7:0]            msg_type_raw,
    input  wire ice_msg_pkg::msg_arg_u msg_arg,
    output logic [3:0]                 led,
    output logic [3:0]                 sd_clk_delay,
    output logic [1:0]                 sd_clk_speed,
    output logic                       sd_init_trigger,
    output logic                       sd_init_reset,
    output logic                       resp_load,
    output logic [63:0]                resp_word
);

    import ice_msg_pkg::*;

    msg_type_t msg_type;
    logic      resp_hit;

    // Zero at power-up and kept across deselect
    logic [3:0] led_q          = 4'h0;
    logic [3:0] clk_delay_q    = 4'h0;
    logic [1:0] clk_speed_q    = 2'h0;
    logic       init_trigger_q = 1'b0;
    logic       init_reset_q   = 1'b0;

    // ==============================
    // Type fix-up and decode
    // ==============================
    // The host's QSPI engine cannot send type bit 7 as one,
    // so it is always forced high here
    assign msg_type = {1'b1, msg_type_raw[`MSG_TYPE_LEN-2:0]};

    // Echo is the only command with a response
    assign resp_hit = (msg_type == `MSG_TYPE_ECHO);

    // ==============================
    // Configuration registers
    // ==============================
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid) begin
            case (msg_type)
                `MSG_TYPE_LEDSET: begin
                    led_q <= msg_arg.led_set.val;
                end
                `MSG_TYPE_SDINIT: begin
                    clk_delay_q <= msg_arg.sd_init.clk_delay;
                    clk_speed_q <= msg_arg.sd_init.clk_speed;
                    // Toggles, so the SD side sees an edge per request
                    if (msg_arg.sd_init.trigger) begin
                        init_trigger_q <= !init_trigger_q;
                    end
                    if (msg_arg.sd_init.reset) begin
                        init_reset_q <= !init_reset_q;
                    end
                end
                `MSG_TYPE_NOP: begin
                end
                default: begin
                    // Unknown types are ignored
                end
            endcase
        end
    end

    // ==============================
    // Response build
    // ==============================
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid && resp_hit) begin
            resp_word[`RESP_ECHO_MSG_BITS] <= msg_arg.echo_msg;
            resp_word[`RESP_TAIL_BITS]     <= '0;
        end
    end

    // One-cycle load pulse to the transmitter
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            resp_load <= 1'b0;
        end else begin
            resp_load <= msg_valid && resp_hit && msg_type[`MSG_TYPE_RESP_BIT];
        end
    end

    assign led             = led_q;
    assign sd_clk_delay    = clk_delay_q;
    assign sd_clk_speed    = clk_speed_q;
    assign sd_init_trigger = init_trigger_q;
    assign sd_init_reset   = init_reset_q;

endmodule

`default_nettype wire

//--- resp_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ice_spi_params.svh"

// Response shift-out, one byte per clock on all eight lines
module resp_transmitter (
    input  wire logic        ice_st_spi_clk,
    input  wire logic        spi_cs,
    input  wire logic        resp_load,
    input  wire logic [63:0] resp_word,
    output logic [7:0]       d_out,
    output logic             d_out_en
);

    localparam int unsigned BYTE_W = `RESP_LEN / `RESP_BYTES;

    logic [`RESP_LEN-1:0] shreg;

    // ==============================
    // Output enable
    // ==============================
    // Stays on until deselect once a response starts
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            d_out_en <= 1'b0;
        end else if (resp_load) begin
            d_out_en <= 1'b1;
        end
    end

    // ==============================
    // Byte shifter
    // ==============================
    // Zeros fill from the bottom, so the lines go quiet
    // after the last byte
    always_ff @(posedge ice_st_spi_clk) begin
        if (resp_load) begin
            shreg <= resp_word;
        end else begin
            shreg <= shreg << BYTE_W;
        end
    end

    // Most significant byte goes out first
    assign d_out = shreg[`RESP_LEN-1 -: BYTE_W];

endmodule

`default_nettype wire

//--- ice_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ice_spi_params.svh"

// STM32 to FPGA quad-SPI command link
module ice_spi_top (
    input  wire logic       ice_st_spi_clk,
    input  wire logic       spi_cs,
    input  wire logic [7:0] d_in,
    output logic [7:0]      d_out,
    output logic            d_out_en,
    output logic [3:0]      led,
    output logic [3:0]      sd_clk_delay,
    output logic [1:0]      sd_clk_speed,
    output logic            sd_init_trigger,
    output logic            sd_init_reset
);

    import ice_msg_pkg::*;

    // Receiver to executor
    logic                     msg_valid;
    logic [`MSG_TYPE_LEN-1:0] msg_type_raw;
    msg_arg_u                 msg_arg;

    // Executor to transmitter
    logic                     resp_load;
    logic [`RESP_LEN-1:0]     resp_word;

    // ==============================
    // Stage 1, message shift-in
    // ==============================
    // Quad mode for commands, d_in[7:4] carry a copy and are ignored
    msg_receiver receiver_i (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .d_nibble       (d_in[3:0]),
        .msg_valid      (msg_valid),
        .msg_type_raw   (msg_type_raw),
        .msg_arg        (msg_arg)
    );

    // ==============================
    // Stage 2, execute
    // ==============================
    msg_executor executor_i (
        .ice_st_spi_clk  (ice_st_spi_clk),
        .spi_cs          (spi_cs),
        .msg_valid       (msg_valid),
        .msg_type_raw    (msg_type_raw),
        .msg_arg         (msg_arg),
        .led             (led),
        .sd_clk_delay    (sd_clk_delay),
        .sd_clk_speed    (sd_clk_speed),
        .sd_init_trigger (sd_init_trigger),
        .sd_init_reset   (sd_init_reset),
        .resp_load       (resp_load),
        .resp_word       (resp_word)
    );

    // ==============================
    // Stage 3, response shift-out
    // ==============================
    resp_transmitter transmitter_i (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp_load      (resp_load),
        .resp_word      (resp_word),
        .d_out          (d_out),
        .d_out_en       (d_out_en)
    );

endmodule

`default_nettype wire

//--- tb_ice_spi.sv
`timescale 1ns/1ps
`default_nettype none

`include "ice_spi_params.svh"

module tb_ice_spi;

    import ice_msg_pkg::*;

    // Cycles allowed between edge 19 and d_out_en
    localparam int RESP_TIMEOUT = 8;
    // Nibbles sent before chip-select drops on an aborted case
    localparam int ABORT_NIBBLES = 10;

    logic       ice_st_spi_clk;
    logic       spi_cs;
    logic [7:0] d_in;
    logic [7:0] d_out;
    logic       d_out_en;
    logic [3:0] led;
    logic [3:0] sd_clk_delay;
    logic [1:0] sd_clk_speed;
    logic       sd_init_trigger;
    logic       sd_init_reset;

    integer seed = 36;
    int     case_cnt = 0;

    // Current case, stimulus and expected values
    logic                    case_abort;
    logic                    case_has_resp;
    logic [7:0]              case_type;
    logic [`MSG_ARG_LEN-1:0] case_arg;
    logic [`RESP_LEN-1:0]    case_resp;
    logic [3:0]              exp_led;
    logic [3:0]              exp_delay;
    logic [1:0]              exp_speed;
    logic                    exp_trig;
    logic                    exp_rst;

    ice_spi_top dut_i (
        .ice_st_spi_clk  (ice_st_spi_clk),
        .spi_cs          (spi_cs),
        .d_in            (d_in),
        .d_out           (d_out),
        .d_out_en        (d_out_en),
        .led             (led),
        .sd_clk_delay    (sd_clk_delay),
        .sd_clk_speed    (sd_clk_speed),
        .sd_init_trigger (sd_init_trigger),
        .sd_init_reset   (sd_init_reset)
    );

    initial begin
        ice_st_spi_clk = 1'b0;
        forever #2 ice_st_spi_clk = ~ice_st_spi_clk;
    end

    // ==============================
    // Error reporting
    // ==============================
    task automatic end_in_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string what);
        $display("[FAIL] %0t ns: case %0d: %s", $time, case_cnt, what);
        end_in_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        end_in_failure();
    endtask

    // ==============================
    // Bus helpers
    // ==============================
    // Two full cycles with chip-select low, ending on a falling edge
    task automatic hold_deselect();
        @(negedge ice_st_spi_clk);
        spi_cs = 1'b0;
        d_in   = 8'h00;
        repeat (2) @(negedge ice_st_spi_clk);
    endtask

    task automatic check_outputs(input string when_str);
        assert (led === exp_led)
            else report_mismatch($sformatf("%s: led %h, expected %h", when_str, led, exp_led));
        assert (sd_clk_delay === exp_delay)
            else report_mismatch($sformatf("%s: sd_clk_delay %h, expected %h",
                                           when_str, sd_clk_delay, exp_delay));
        assert (sd_clk_speed === exp_speed)
            else report_mismatch($sformatf("%s: sd_clk_speed %h, expected %h",
                                           when_str, sd_clk_speed, exp_speed));
        assert (sd_init_trigger === exp_trig)
            else report_mismatch($sformatf("%s: sd_init_trigger %b, expected %b",
                                           when_str, sd_init_trigger, exp_trig));
        assert (sd_init_reset === exp_rst)
            else report_mismatch($sformatf("%s: sd_init_reset %b, expected %b",
                                           when_str, sd_init_reset, exp_rst));
    endtask

    // ==============================
    // One transaction
    // ==============================
    // Starts on a falling edge with chip-select low
    task automatic run_case();
        logic [3:0]          nib [0:`MSG_NIBBLES-1];
        logic [`MSG_LEN-1:0] message;
        logic [31:0]         dummy;
        msg_arg_u            arg_v;
        int                  n_send;
        int                  edge_no;
        int                  i;
        arg_v   = case_arg;
        message = {case_type, arg_v.echo_msg};
        dummy   = $random(seed);
        nib[0]  = dummy[3:0];
        nib[1]  = dummy[7:4];
        for (i = 0; i < `MSG_LEN / 4; i++) begin
            nib[`DUMMY_NIBBLES + i] = message[`MSG_LEN-1-4*i -: 4];
        end

        n_send = case_abort ? ABORT_NIBBLES : `MSG_NIBBLES;
        spi_cs = 1'b1;
        // Upper lines carry the inverse and must be ignored
        for (i = 0; i < n_send; i++) begin
            d_in = {~nib[i], nib[i]};
            @(negedge ice_st_spi_clk);
        end
        edge_no = n_send;
        d_in    = 8'h00;

        if (case_abort) begin
            assert (d_out_en === 1'b0)
                else report_mismatch("d_out_en high during aborted transaction");
            spi_cs = 1'b0;
            repeat (2) @(negedge ice_st_spi_clk);
            check_outputs("after aborted transaction");
        end else begin
            @(negedge ice_st_spi_clk);
            edge_no++;
            check_outputs("after edge 19");
            assert (d_out_en === 1'b0)
                else report_mismatch("d_out_en high after edge 19");
            if (case_has_resp) begin
                while (d_out_en !== 1'b1 && edge_no < `MSG_NIBBLES + 1 + RESP_TIMEOUT) begin
                    @(negedge ice_st_spi_clk);
                    edge_no++;
                end
                if (d_out_en !== 1'b1) begin
                    report_error("timeout waiting for d_out_en on an echo response");
                end
                assert (edge_no == `MSG_NIBBLES + 2)
                    else report_mismatch($sformatf("d_out_en rose after edge %0d, expected %0d",
                                                   edge_no, `MSG_NIBBLES + 2));
                // Most significant byte first
                for (i = 0; i < `RESP_BYTES; i++) begin
                    assert (d_out_en === 1'b1)
                        else report_mismatch($sformatf("d_out_en low at response byte %0d", i));
                    assert (d_out === case_resp[`RESP_LEN-1-8*i -: 8])
                        else report_mismatch($sformatf("response byte %0d is %h, expected %h",
                                                       i, d_out, case_resp[`RESP_LEN-1-8*i -: 8]));
                    @(negedge ice_st_spi_clk);
                    edge_no++;
                end
                assert (d_out === 8'h00 && d_out_en === 1'b1)
                    else report_mismatch($sformatf("after response d_out %h d_out_en %b",
                                                   d_out, d_out_en));
            end else begin
                repeat (`RESP_BYTES + 1) begin
                    @(negedge ice_st_spi_clk);
                    assert (d_out_en === 1'b0)
                        else report_mismatch("d_out_en high for a command without response");
                end
            end
            check_outputs("end of transaction");
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int    fd;
        int    n_fields;
        int    mode;
        int    has_resp;
        string line;
        spi_cs        = 1'b0;
        d_in          = 8'h00;
        case_abort    = 1'b0;
        case_has_resp = 1'b0;

        fd = $fopen("ice_spi_cases.txt", "r");
        if (fd == 0) begin
            report_error("could not open ice_spi_cases.txt");
        end

        hold_deselect();
        assert (d_out_en === 1'b0) else report_mismatch("d_out_en high during reset");

        while (!$feof(fd)) begin
            line     = "";
            n_fields = $fgets(line, fd);
            // Blank lines and comments
            if (line.len() < 4 || line[0] == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%d %h %h %h %h %h %h %h %d %h",
                               mode, case_type, case_arg, exp_led, exp_delay,
                               exp_speed, exp_trig, exp_rst, has_resp, case_resp);
            if (n_fields != 10) begin
                report_error($sformatf("malformed line in ice_spi_cases.txt: %s", line));
            end
            case_abort    = (mode != 0);
            case_has_resp = (has_resp != 0);
            hold_deselect();
            run_case();
            case_cnt++;
        end
        $fclose(fd);
        hold_deselect();

        if (case_cnt > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_error("no cases found in ice_spi_cases.txt");
        end
    end

endmodule

`default_nettype wire

//--- ice_spi_cases.txt
# mode type arg led delay speed trigger reset has_resp resp
# mode 0 full transaction, 1 chip-select dropped after 10 nibbles; values in hex
# Echo, and bit 7 forced high
0 C0 0123456789ABCD 0 0 0 0 0 1 0123456789ABCD00
0 40 FEDCBA98765432 0 0 0 0 0 1 FEDCBA9876543200

# LEDSet, value kept across Nop
0 81 0000000000000A A 0 0 0 0 0 0000000000000000
0 80 FFFFFFFFFFFFFF A 0 0 0 0 0 0000000000000000
0 01 00000000000005 5 0 0 0 0 0 0000000000000000

# SDInit toggles over consecutive commands
0 82 0000000000003A 5 3 2 1 0 0 0000000000000000
0 82 00000000000075 5 7 1 1 1 0 0000000000000000
0 82 000000000000FF 5 F 3 0 0 0 0000000000000000
0 82 00000000000000 5 0 0 0 0 0 0000000000000000

# Unknown types
0 8F FFFFFFFFFFFFFF 5 0 0 0 0 0 0000000000000000
0 3C 123456789ABCDE 5 0 0 0 0 0 0000000000000000

# Aborted transactions
1 81 0000000000000C 5 0 0 0 0 0 0000000000000000
1 82 000000000000FF 5 0 0 0 0 0 0000000000000000
1 C0 0123456789ABCD 5 0 0 0 0 0 0000000000000000

# Echo after an abort
0 C0 00000000000000 5 0 0 0 0 1 0000000000000000
0 C0 A5A5A5A5A5A5A5 5 0 0 0 0 1 A5A5A5A5A5A5A500

# Pad bits ignored
0 81 FFFFFFFFFFFFF3 3 0 0 0 0 0 0000000000000000
0 82 ABCDEF12345602 3 0 0 1 0 0 0000000000000000
0 80 00000000000000 3 0 0 1 0 0 0000000000000000

# Response bit set but not Echo
0 7F FFFFFFFFFFFFFF 3 0 0 1 0 0 0000000000000000
0 C0 11223344556677 3 0 0 1 0 1 1122334455667700
0 82 00000000000043 3 4 0 0 1 0 0000000000000000
0 81 00000000000000 0 4 0 0 1 0 0000000000000000
0 40 00000000000001 0 4 0 0 1 1 0000000000000100
0 02 000000000000B1 0 B 0 0 0 0 0000000000000000
0 80 00000000000000 0 B 0 0 0 0 0000000000000000

//--- flist.f
+incdir+.
ice_msg_pkg.sv
msg_receiver.sv
msg_executor.sv
resp_transmitter.sv
ice_spi_top.sv
tb_ice_spi.sv
